//--- common/uart_bus_pkg.sv
package uart_bus_pkg;

   // ----------------------------------------
   // register side widths
   // ----------------------------------------
   typedef logic [2:0]  reg_addr_t;    // byte address inside the uart
   typedef logic [7:0]  reg_byte_t;    // one register byte
   typedef logic [31:0] apb_word_t;    // full apb data/address word

   // ----------------------------------------
   // register map
   // ----------------------------------------
   // a data write loads thr and a data read returns the rx buffer
   localparam reg_addr_t ADDR_DATA    = 3'd0;
   localparam reg_addr_t ADDR_DIV_LO  = 3'd1;  // divisor low byte
   localparam reg_addr_t ADDR_DIV_HI  = 3'd2;  // divisor high byte
   localparam reg_addr_t ADDR_LSR     = 3'd3;  // line status, read only
   localparam reg_addr_t ADDR_SCRATCH = 3'd7;

   // ----------------------------------------
   // line status bits
   // ----------------------------------------
   localparam int LSR_DR   = 0;  // data ready
   localparam int LSR_OE   = 1;  // overrun
   localparam int LSR_FE   = 3;  // framing error
   localparam int LSR_TEMT = 5;  // transmitter idle

endpackage

//--- common/uart_line_pkg.sv
package uart_line_pkg;

   // ----------------------------------------
   // baud generation
   // ----------------------------------------
   typedef logic [15:0] baud_div_t;           // clocks per oversample tick

   localparam int        OVERSAMPLE = 16;     // ticks per bit
   localparam baud_div_t DIV_RESET  = 16'd1;  // divisor out of reset

   typedef logic [3:0] sample_cnt_t;          // counts ticks within a bit
   typedef logic [2:0] bit_cnt_t;             // data bit index 0..7

   // ----------------------------------------
   // frame state machines
   // ----------------------------------------
   typedef enum logic [1:0] {
      TX_IDLE,
      TX_START,
      TX_DATA,
      TX_STOP
   } tx_state_t;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,   // waiting for start bit midpoint
      RX_DATA,
      RX_STOP
   } rx_state_t;

endpackage

//--- common/uart_reg_if.sv
interface uart_reg_if;

   import uart_bus_pkg::*;

   logic      reg_we;     // one-cycle write strobe
   logic      reg_re;     // one-cycle read strobe
   reg_addr_t reg_adr;
   reg_byte_t reg_wdata;  // byte lane already selected
   reg_byte_t reg_rdata;  // valid the cycle after reg_re

   // apb side
   modport bridge (
      output reg_we, reg_re, reg_adr, reg_wdata,
      input  reg_rdata
   );

   // register file side
   modport regs (
      input  reg_we, reg_re, reg_adr, reg_wdata,
      output reg_rdata
   );

endinterface

//--- hdl/uart_apb_bridge.sv
module uart_apb_bridge (
   input  logic                   clock,
   input  logic                   reset_i,
   input  logic                   psel_i,
   input  logic                   penable_i,
   input  logic                   pwrite_i,
   input  uart_bus_pkg::apb_word_t paddr_i,
   input  uart_bus_pkg::apb_word_t pwdata_i,
   output logic                   pready_o,
   output uart_bus_pkg::apb_word_t prdata_o,
   uart_reg_if.bridge             reg_bus
);

   import uart_bus_pkg::*;

   logic      setup_w;     // psel high, penable low
   logic      setup_q;     // setup seen on last cycle
   logic      first_w;     // first cycle of a setup phase
   reg_byte_t lane_byte;

   assign setup_w = psel_i & ~penable_i;
   assign first_w = setup_w & ~setup_q;  // a stretched setup strobes only once

   // remembers the setup cycle so the strobe stays a single pulse
   always_ff @(posedge clock) begin
      if (reset_i) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= setup_w;
      end
   end

   assign reg_bus.reg_we  = first_w &  pwrite_i & ~reset_i;
   assign reg_bus.reg_re  = first_w & ~pwrite_i & ~reset_i;
   assign reg_bus.reg_adr = paddr_i[2:0];

   // little-endian lane pick
   always_comb begin
      case (paddr_i[1:0])
         2'b00:   lane_byte = pwdata_i[7:0];
         2'b01:   lane_byte = pwdata_i[15:8];
         2'b10:   lane_byte = pwdata_i[23:16];
         default: lane_byte = pwdata_i[31:24];
      endcase
   end
   assign reg_bus.reg_wdata = lane_byte;

   assign pready_o = psel_i & penable_i;  // no wait states
   assign prdata_o = psel_i ? {4{reg_bus.reg_rdata}} : '0;  // byte on every lane

endmodule

//--- uart_core/uart_baud_timer.sv
module uart_baud_timer (
   input  logic                    clock,
   input  logic                    reset_i,
   input  uart_line_pkg::baud_div_t divisor_i,
   input  logic                    reload_i,
   output logic                    tick_o
);

   import uart_line_pkg::*;

   baud_div_t div_eff;  // zero acts as one
   baud_div_t cnt_q;

   assign div_eff = (divisor_i == '0) ? baud_div_t'(1) : divisor_i;

   // counts down to one, then reloads
   always_ff @(posedge clock) begin
      if (reset_i) begin
         cnt_q <= DIV_RESET;
      end else if (reload_i) begin
         cnt_q <= div_eff;  // restart on a divisor write
      end else if (cnt_q == baud_div_t'(1)) begin
         cnt_q <= div_eff;
      end else begin
         cnt_q <= cnt_q - 1'b1;
      end
   end

   assign tick_o = (cnt_q == baud_div_t'(1));  // once every div_eff clocks

endmodule

//--- uart_core/uart_tx.sv
module uart_tx (
   input  logic                    clock,
   input  logic                    reset_i,
   input  logic                    tick_i,
   input  logic                    start_i,
   input  uart_bus_pkg::reg_byte_t data_i,
   output logic                    busy_o,
   output logic                    tx_o
);

   import uart_bus_pkg::*;
   import uart_line_pkg::*;

   tx_state_t   state_q;
   sample_cnt_t tick_cnt_q;
   bit_cnt_t    bit_cnt_q;
   reg_byte_t   shift_q;
   logic        pend_q;    // byte latched and waiting for the next tick
   logic        tx_q;
   logic        bit_end_w;

   assign bit_end_w = tick_i & (tick_cnt_q == sample_cnt_t'(OVERSAMPLE - 1));

   always_ff @(posedge clock) begin
      if (reset_i) begin
         state_q    <= TX_IDLE;
         pend_q     <= 1'b0;
         tx_q       <= 1'b1;  // line idles high
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
      end else begin
         if (tick_i) tick_cnt_q <= tick_cnt_q + 1'b1;  // wraps every bit
         case (state_q)
            TX_IDLE: begin
               if (start_i && !pend_q) begin
                  shift_q <= data_i;
                  pend_q  <= 1'b1;
               end else if (pend_q && tick_i) begin
                  pend_q     <= 1'b0;
                  state_q    <= TX_START;
                  tx_q       <= 1'b0;  // start bit
                  tick_cnt_q <= '0;
               end
            end
            TX_START: begin
               if (bit_end_w) begin
                  state_q   <= TX_DATA;
                  tx_q      <= shift_q[0];  // lsb first
                  bit_cnt_q <= '0;
               end
            end
            TX_DATA: begin
               if (bit_end_w) begin
                  if (bit_cnt_q == bit_cnt_t'(7)) begin
                     state_q <= TX_STOP;
                     tx_q    <= 1'b1;
                  end else begin
                     shift_q   <= shift_q >> 1;
                     tx_q      <= shift_q[1];
                     bit_cnt_q <= bit_cnt_q + 1'b1;
                  end
               end
            end
            default: begin  // stop bit
               if (bit_end_w) state_q <= TX_IDLE;
            end
         endcase
      end
   end

   assign busy_o = pend_q | (state_q != TX_IDLE);
   assign tx_o   = tx_q;

endmodule

//--- uart_core/uart_rx.sv
module uart_rx (
   input  logic                    clock,
   input  logic                    reset_i,
   input  logic                    tick_i,
   input  logic                    rx_i,
   output logic                    valid_o,
   output uart_bus_pkg::reg_byte_t data_o,
   output logic                    frame_err_o
);

   import uart_bus_pkg::*;
   import uart_line_pkg::*;

   rx_state_t   state_q;
   sample_cnt_t tick_cnt_q;
   bit_cnt_t    bit_cnt_q;
   reg_byte_t   shift_q;
   logic        rx_s1_q;
   logic        rx_s2_q;   // synchronized line
   logic        rx_d_q;    // previous sample for edge detect
   logic        valid_q;
   logic        fe_q;
   logic        mid_w;     // start bit midpoint
   logic        bit_end_w; // one full bit later

   assign mid_w     = tick_i & (tick_cnt_q == sample_cnt_t'(OVERSAMPLE / 2 - 1));
   assign bit_end_w = tick_i & (tick_cnt_q == sample_cnt_t'(OVERSAMPLE - 1));

   // ----------------------------------------
   // input sync
   // ----------------------------------------
   always_ff @(posedge clock) begin
      if (reset_i) begin
         rx_s1_q <= 1'b1;
         rx_s2_q <= 1'b1;
         rx_d_q  <= 1'b1;
      end else begin
         rx_s1_q <= rx_i;
         rx_s2_q <= rx_s1_q;
         rx_d_q  <= rx_s2_q;
      end
   end

   always_ff @(posedge clock) begin
      if (reset_i) begin
         state_q    <= RX_IDLE;
         tick_cnt_q <= '0;
         bit_cnt_q  <= '0;
         valid_q    <= 1'b0;
         fe_q       <= 1'b0;
      end else begin
         valid_q <= 1'b0;  // single pulse
         if (tick_i) tick_cnt_q <= tick_cnt_q + 1'b1;
         case (state_q)
            RX_IDLE: begin
               if (rx_d_q && !rx_s2_q) begin  // falling edge
                  state_q    <= RX_START;
                  tick_cnt_q <= '0;
               end
            end
            RX_START: begin
               if (mid_w) begin
                  tick_cnt_q <= '0;  // later samples land mid-bit
                  bit_cnt_q  <= '0;
                  state_q    <= rx_s2_q ? RX_IDLE : RX_DATA;  // glitch goes back
               end
            end
            RX_DATA: begin
               if (bit_end_w) begin
                  shift_q <= {rx_s2_q, shift_q[7:1]};  // lsb arrives first
                  if (bit_cnt_q == bit_cnt_t'(7)) state_q <= RX_STOP;
                  else bit_cnt_q <= bit_cnt_q + 1'b1;
               end
            end
            default: begin
               if (bit_end_w) begin
                  valid_q <= 1'b1;
                  fe_q    <= ~rx_s2_q;  // stop bit must be high
                  state_q <= RX_IDLE;
               end
            end
         endcase
      end
   end

   assign valid_o     = valid_q;
   assign data_o      = shift_q;
   assign frame_err_o = fe_q;

endmodule

//--- uart_core/uart_regs.sv
module uart_regs (
   input  logic     clock,
   input  logic     reset_i,
   uart_reg_if.regs reg_bus,
   input  logic     rx_i,
   output logic     tx_o
);

   import uart_bus_pkg::*;
   import uart_line_pkg::*;

   baud_div_t div_q;
   logic      div_load_q;   // reload the timer once the new value is in
   reg_byte_t scratch_q;
   reg_byte_t rx_buf_q;
   reg_byte_t rdata_q;
   reg_byte_t lsr_w;
   logic      dr_q;
   logic      oe_q;
   logic      fe_q;

   logic      wr_div_w;
   logic      wr_data_w;
   logic      rd_data_w;
   logic      rd_lsr_w;

   logic      tick;
   logic      tx_start;
   logic      tx_busy;
   logic      rx_valid;
   reg_byte_t rx_byte;
   logic      rx_frame_err;

   // ----------------------------------------
   // address decode
   // ----------------------------------------
   assign wr_div_w  = reg_bus.reg_we &
                      (reg_bus.reg_adr == ADDR_DIV_LO || reg_bus.reg_adr == ADDR_DIV_HI);
   assign wr_data_w = reg_bus.reg_we & (reg_bus.reg_adr == ADDR_DATA);
   assign rd_data_w = reg_bus.reg_re & (reg_bus.reg_adr == ADDR_DATA);
   assign rd_lsr_w  = reg_bus.reg_re & (reg_bus.reg_adr == ADDR_LSR);

   assign tx_start  = wr_data_w & ~tx_busy;  // dropped while sending

   // divisor and timer reload
   always_ff @(posedge clock) begin
      if (reset_i) begin
         div_q      <= DIV_RESET;
         div_load_q <= 1'b0;
      end else begin
         div_load_q <= wr_div_w;
         if (reg_bus.reg_we && reg_bus.reg_adr == ADDR_DIV_LO) div_q[7:0]  <= reg_bus.reg_wdata;
         if (reg_bus.reg_we && reg_bus.reg_adr == ADDR_DIV_HI) div_q[15:8] <= reg_bus.reg_wdata;
      end
   end

   always_ff @(posedge clock) begin
      if (reg_bus.reg_we && reg_bus.reg_adr == ADDR_SCRATCH) scratch_q <= reg_bus.reg_wdata;
      if (rx_valid) rx_buf_q <= rx_byte;  // newest byte always kept
   end

   // ----------------------------------------
   // line status flags
   // ----------------------------------------
   always_ff @(posedge clock) begin
      if (reset_i) begin
         dr_q <= 1'b0;
         oe_q <= 1'b0;
         fe_q <= 1'b0;
      end else begin
         if (rx_valid)       dr_q <= 1'b1;
         else if (rd_data_w) dr_q <= 1'b0;
         // old byte lost unless read in this very cycle
         if (rx_valid && dr_q && !rd_data_w) oe_q <= 1'b1;
         else if (rd_lsr_w)                  oe_q <= 1'b0;
         if (rx_valid && rx_frame_err) fe_q <= 1'b1;
         else if (rd_lsr_w)            fe_q <= 1'b0;
      end
   end

   always_comb begin
      lsr_w           = '0;
      lsr_w[LSR_DR]   = dr_q;
      lsr_w[LSR_OE]   = oe_q;
      lsr_w[LSR_FE]   = fe_q;
      lsr_w[LSR_TEMT] = ~tx_busy;
   end

   // read data lands in the access phase
   always_ff @(posedge clock) begin
      if (reg_bus.reg_re) begin
         case (reg_bus.reg_adr)
            ADDR_DATA:    rdata_q <= rx_buf_q;
            ADDR_DIV_LO:  rdata_q <= div_q[7:0];
            ADDR_DIV_HI:  rdata_q <= div_q[15:8];
            ADDR_LSR:     rdata_q <= lsr_w;
            ADDR_SCRATCH: rdata_q <= scratch_q;
            default:      rdata_q <= '0;  // unmapped
         endcase
      end
   end
   assign reg_bus.reg_rdata = rdata_q;

   // ----------------------------------------
   // serial engines
   // ----------------------------------------
   uart_baud_timer u_timer (
      .clock     (clock),
      .reset_i   (reset_i),
      .divisor_i (div_q),
      .reload_i  (div_load_q),
      .tick_o    (tick)
   );

   uart_tx u_tx (
      .clock   (clock),
      .reset_i (reset_i),
      .tick_i  (tick),
      .start_i (tx_start),
      .data_i  (reg_bus.reg_wdata),
      .busy_o  (tx_busy),
      .tx_o    (tx_o)
   );

   uart_rx u_rx (
      .clock       (clock),
      .reset_i     (reset_i),
      .tick_i      (tick),
      .rx_i        (rx_i),
      .valid_o     (rx_valid),
      .data_o      (rx_byte),
      .frame_err_o (rx_frame_err)
   );

endmodule

//--- hdl/uart_top_apb.sv
module uart_top_apb (
   input  logic        clock,
   input  logic        reset_i,
   input  logic        psel_i,
   input  logic        penable_i,
   input  logic        pwrite_i,
   input  logic [31:0] paddr_i,
   input  logic [31:0] pwdata_i,
   output logic        pready_o,
   output logic [31:0] prdata_o,
   input  logic        uart_rx_i,   // serial in
   output logic        uart_tx_o    // serial out
);

   uart_reg_if reg_bus ();  // byte strobes between bridge and core

   // ----------------------------------------
   // apb side
   // ----------------------------------------
   uart_apb_bridge u_bridge (
      .clock     (clock),
      .reset_i   (reset_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .pready_o  (pready_o),
      .prdata_o  (prdata_o),
      .reg_bus   (reg_bus.bridge)
   );

   // registers plus tx/rx
   uart_regs u_regs (
      .clock   (clock),
      .reset_i (reset_i),
      .reg_bus (reg_bus.regs),
      .rx_i    (uart_rx_i),
      .tx_o    (uart_tx_o)
   );

endmodule

//--- verification/tb_uart_top_apb.sv
module tb_uart_top_apb;

   import uart_bus_pkg::*;
   import uart_line_pkg::*;

   localparam int READY_TMO = 8;    // cycles allowed for pready
   localparam int POLL_TMO  = 100;  // status reads before giving up

   logic      clock;
   logic      reset_i;
   logic      psel_i;
   logic      penable_i;
   logic      pwrite_i;
   apb_word_t paddr_i;
   apb_word_t pwdata_i;
   logic      pready_o;
   apb_word_t prdata_o;
   logic      uart_rx_i;
   logic      uart_tx_o;

   integer    seed;
   int        n_checks;
   int        n_errors;
   int        n_timeouts;

   // reference model state
   baud_div_t m_div;
   reg_byte_t m_scratch;
   reg_byte_t m_rxbuf;
   logic      m_dr;
   logic      m_oe;
   logic      m_fe;

   uart_top_apb dut0 (
      .clock     (clock),
      .reset_i   (reset_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .pready_o  (pready_o),
      .prdata_o  (prdata_o),
      .uart_rx_i (uart_rx_i),
      .uart_tx_o (uart_tx_o)
   );

   initial begin
      clock = 1'b0;
      forever #20 clock = ~clock;
   end

   // ----------------------------------------
   // checking and model
   // ----------------------------------------
   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         n_errors++;
         $display("CHECK FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic note_timeout(input string what);
      n_timeouts++;
      $display("TIMEOUT t=%0t: gave up waiting for %s", $time, what);
   endtask

   function automatic reg_byte_t model_lsr();
      reg_byte_t v;
      v           = '0;
      v[LSR_DR]   = m_dr;
      v[LSR_OE]   = m_oe;
      v[LSR_FE]   = m_fe;
      v[LSR_TEMT] = 1'b1;  // status only compared with tx idle
      return v;
   endfunction

   function automatic reg_byte_t model_reg(input reg_addr_t adr);
      case (adr)
         ADDR_DIV_LO: return m_div[7:0];
         ADDR_DIV_HI: return m_div[15:8];
         default:     return m_scratch;
      endcase
   endfunction

   task automatic model_rx(input reg_byte_t b, input logic stop_bit);
      if (m_dr) m_oe = 1'b1;  // older byte never read
      m_dr    = 1'b1;
      m_rxbuf = b;            // newest byte wins
      if (!stop_bit) m_fe = 1'b1;
   endtask

   // ----------------------------------------
   // apb master
   // ----------------------------------------
   task automatic wait_ready();
      int n;
      n = 0;
      @(posedge clock);
      while (!pready_o && n < READY_TMO) begin
         @(posedge clock);
         n++;
      end
      if (!pready_o) note_timeout("pready_o");
   endtask

   task automatic apb_xfer(input logic wr, input reg_addr_t adr, input reg_byte_t wbyte,
                           output apb_word_t rword);
      apb_word_t word;
      integer    rnd;
      rnd  = $random(seed);
      word = apb_word_t'(rnd);  // junk on the other lanes
      case (adr[1:0])
         2'd0:    word[7:0]   = wbyte;
         2'd1:    word[15:8]  = wbyte;
         2'd2:    word[23:16] = wbyte;
         default: word[31:24] = wbyte;
      endcase
      @(negedge clock);
      check_val("prdata_o (idle)", prdata_o, 32'h0);  // bus parked
      psel_i    = 1'b1;  // setup
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = {29'd0, adr};
      pwdata_i  = word;
      @(negedge clock);
      check_val("pready_o (setup)", 32'(pready_o), 32'h0);
      penable_i = 1'b1;  // access
      wait_ready();
      @(negedge clock);
      rword     = prdata_o;  // psel still high here
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
   endtask

   task automatic apb_write(input reg_addr_t adr, input reg_byte_t wbyte);
      apb_word_t unused;
      apb_xfer(1'b1, adr, wbyte, unused);
   endtask

   task automatic apb_read(input reg_addr_t adr, output reg_byte_t rbyte);
      apb_word_t word;
      apb_xfer(1'b0, adr, 8'h00, word);
      check_val("prdata_o lanes", word, {4{word[7:0]}});  // same byte everywhere
      rbyte = word[7:0];
   endtask

   task automatic set_divisor(input baud_div_t d);
      apb_write(ADDR_DIV_LO, d[7:0]);
      apb_write(ADDR_DIV_HI, d[15:8]);
      m_div = d;
   endtask

   task automatic read_lsr_check(input string what);
      reg_byte_t v;
      apb_read(ADDR_LSR, v);
      check_val(what, 32'(v), 32'(model_lsr()));
      m_oe = 1'b0;
      m_fe = 1'b0;
   endtask

   task automatic read_data_check();
      reg_byte_t v;
      apb_read(ADDR_DATA, v);
      check_val("prdata_o (rx data)", 32'(v), 32'(m_rxbuf));
      m_dr = 1'b0;
   endtask

   // polls status until a bit in mask is set, then compares the whole byte
   task automatic wait_lsr(input reg_byte_t mask, input string what);
      reg_byte_t v;
      int        n;
      logic      seen;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < POLL_TMO) begin
         apb_read(ADDR_LSR, v);
         n++;
         seen = |(v & mask);
         if (seen) check_val(what, 32'(v), 32'(model_lsr()));
         m_oe = 1'b0;  // every status read clears these
         m_fe = 1'b0;
      end
      if (!seen) note_timeout(what);
   endtask

   // ----------------------------------------
   // serial side
   // ----------------------------------------
   task automatic send_frame(input reg_byte_t b, input logic stop_bit);
      reg_byte_t sh;
      int        bit_clks;
      sh       = b;
      bit_clks = OVERSAMPLE * int'(m_div);
      @(negedge clock);
      uart_rx_i = 1'b0;  // start
      repeat (bit_clks) @(negedge clock);
      repeat (8) begin
         uart_rx_i = sh[0];  // lsb first
         sh        = sh >> 1;
         repeat (bit_clks) @(negedge clock);
      end
      uart_rx_i = stop_bit;
      repeat (bit_clks) @(negedge clock);
      uart_rx_i = 1'b1;  // idle gap
      repeat (bit_clks) @(negedge clock);
   endtask

   task automatic capture_tx(output reg_byte_t b, output logic ok);
      int   bit_clks;
      int   n;
      logic low_seen;
      bit_clks = OVERSAMPLE * int'(m_div);
      b        = '0;
      low_seen = 1'b0;
      n        = 0;
      while (!low_seen && n < 4 * bit_clks + 64) begin
         @(negedge clock);
         n++;
         low_seen = ~uart_tx_o;
      end
      ok = low_seen;
      if (!low_seen) begin
         note_timeout("start bit on uart_tx_o");
      end else begin
         repeat (bit_clks / 2) @(negedge clock);  // centre of start bit
         check_val("uart_tx_o (start)", 32'(uart_tx_o), 32'h0);
         repeat (8) begin
            repeat (bit_clks) @(negedge clock);
            b = {uart_tx_o, b[7:1]};
         end
         repeat (bit_clks) @(negedge clock);
         check_val("uart_tx_o (stop)", 32'(uart_tx_o), 32'h1);
      end
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------
   initial begin
      reg_byte_t b;
      reg_byte_t b2;
      reg_byte_t got;
      reg_addr_t adr;
      logic      ok;
      logic      line_min;
      integer    rnd;

      seed       = 7895;
      n_checks   = 0;
      n_errors   = 0;
      n_timeouts = 0;
      reset_i    = 1'b1;
      psel_i     = 1'b0;
      penable_i  = 1'b0;
      pwrite_i   = 1'b0;
      paddr_i    = '0;
      pwdata_i   = '0;
      uart_rx_i  = 1'b1;  // line idle
      m_div      = DIV_RESET;
      m_scratch  = '0;
      m_rxbuf    = '0;
      m_dr       = 1'b0;
      m_oe       = 1'b0;
      m_fe       = 1'b0;
      repeat (8) @(posedge clock);
      @(negedge clock);
      reset_i = 1'b0;

      // state out of reset
      read_lsr_check("prdata_o (lsr after reset)");
      check_val("uart_tx_o", 32'(uart_tx_o), 32'h1);

      // register readback with random order and data
      repeat (12) begin
         rnd = $random(seed);
         b   = rnd[7:0];
         case (rnd[9:8])
            2'd0:    adr = ADDR_DIV_LO;
            2'd1:    adr = ADDR_DIV_HI;
            default: adr = ADDR_SCRATCH;
         endcase
         apb_write(adr, b);
         if (adr == ADDR_DIV_LO) m_div[7:0] = b;
         else if (adr == ADDR_DIV_HI) m_div[15:8] = b;
         else m_scratch = b;
         apb_read(adr, got);
         check_val("prdata_o (readback)", 32'(got), 32'(model_reg(adr)));
      end

      // transmit path
      rnd = $random(seed);
      set_divisor(baud_div_t'(1 + rnd[1:0]));
      repeat (3) begin
         rnd = $random(seed);
         b   = rnd[7:0];
         fork
            capture_tx(got, ok);
            apb_write(ADDR_DATA, b);
         join
         if (ok) check_val("uart_tx_o (byte)", 32'(got), 32'(b));
         wait_lsr(reg_byte_t'(1 << LSR_TEMT), "prdata_o (lsr tx idle)");
      end

      // receive path
      rnd = $random(seed);
      set_divisor(baud_div_t'(1 + rnd[1:0]));
      repeat (4) begin
         rnd = $random(seed);
         b   = rnd[7:0];
         send_frame(b, 1'b1);
         model_rx(b, 1'b1);
         wait_lsr(reg_byte_t'(1 << LSR_DR), "prdata_o (lsr data ready)");
         read_data_check();
         read_lsr_check("prdata_o (lsr after data read)");
      end

      // overrun and then a bad stop bit
      rnd = $random(seed);
      b   = rnd[7:0];
      b2  = rnd[15:8];
      send_frame(b, 1'b1);
      model_rx(b, 1'b1);
      send_frame(b2, 1'b1);
      model_rx(b2, 1'b1);
      wait_lsr(reg_byte_t'(1 << LSR_OE), "prdata_o (lsr overrun)");
      read_data_check();
      read_lsr_check("prdata_o (lsr after overrun)");
      b = rnd[23:16];
      send_frame(b, 1'b0);
      model_rx(b, 1'b0);
      wait_lsr(reg_byte_t'(1 << LSR_FE), "prdata_o (lsr framing)");
      read_lsr_check("prdata_o (lsr fe cleared)");
      read_data_check();
      read_lsr_check("prdata_o (lsr all clear)");

      // second byte while busy must vanish
      rnd = $random(seed);
      b   = rnd[7:0];
      b2  = rnd[15:8];
      fork
         capture_tx(got, ok);
         begin
            apb_write(ADDR_DATA, b);
            apb_write(ADDR_DATA, b2);
         end
      join
      if (ok) check_val("uart_tx_o (first byte)", 32'(got), 32'(b));
      line_min = 1'b1;
      repeat (12 * OVERSAMPLE * int'(m_div)) begin
         @(negedge clock);
         line_min = line_min & uart_tx_o;  // any low sample means a frame
      end
      check_val("uart_tx_o (idle after drop)", 32'(line_min), 32'h1);
      wait_lsr(reg_byte_t'(1 << LSR_TEMT), "prdata_o (lsr tx idle)");

      $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
      if (n_errors == 0 && n_timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- uart_top_apb.f
common/uart_bus_pkg.sv
common/uart_line_pkg.sv
common/uart_reg_if.sv
hdl/uart_apb_bridge.sv
uart_core/uart_baud_timer.sv
uart_core/uart_tx.sv
uart_core/uart_rx.sv
uart_core/uart_regs.sv
hdl/uart_top_apb.sv
verification/tb_uart_top_apb.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = tb_uart_top_apb
FLIST = uart_top_apb.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '>>> PASS'

clean:
	rm -rf obj_dir
